// File: source/column_buffer.sv
// One access per cycle with reads first and the contents are undefined until written
`include "pov_consts.svh"

module column_buffer (
    input  logic                       clk,
    input  pov_pkg::col_wr_t           col_wr,
    output logic                       col_grant,
    input  logic                       rd_req,
    input  logic [`POV_SLICE_BITS-1:0] slice_cnt,
    input  logic [`POV_SLICE_BITS-1:0] slice_offset,
    output logic [`POV_LEDS-1:0]       rd_data
);

    logic [`POV_LEDS-1:0]       mem [`POV_SLICES];
    logic [`POV_SLICE_BITS-1:0] rd_addr;

    // Slice plus offset, the slice-width sum wraps modulo the slice count
    assign rd_addr = slice_cnt + slice_offset;

    assign col_grant = col_wr.req & ~rd_req;

    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_data <= mem[rd_addr];
        end else if (col_grant) begin
            mem[col_wr.addr] <= col_wr.data;
        end
    end

endmodule

// File: source/display_regs.sv
// Enable takes data bit 0 and the offset takes the low slice bits, other bits are ignored
`include "pov_consts.svh"

module display_regs (
    input  logic                       clk,
    input  logic                       arst_n,
    input  pov_pkg::reg_wr_t           reg_wr,
    output logic                       display_enable,
    output logic [`POV_SLICE_BITS-1:0] slice_offset
);

    import pov_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            display_enable <= 1'b0;
            slice_offset   <= '0;
        end else if (reg_wr.valid) begin
            case (reg_wr.op)
                op_enable: begin
                    display_enable <= reg_wr.data[0];
                end
                // Rotates the image against the hall position
                op_offset: begin
                    slice_offset <= reg_wr.data[`POV_SLICE_BITS-1:0];
                end
                default: begin
                    display_enable <= display_enable;
                end
            endcase
        end
    end

endmodule

// File: source/hall_counter.sv
// Single hall input sampled on clk and turn_period saturates at its all-ones value
`include "pov_consts.svh"

module hall_counter (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        hall,
    output logic                        turn_start,
    output logic [`POV_PERIOD_BITS-1:0] turn_period
);

    localparam logic [`POV_PERIOD_BITS-1:0] PERIOD_MAX = '1;
    localparam logic [`POV_PERIOD_BITS-1:0] PERIOD_ONE = `POV_PERIOD_BITS'(1);

    logic                        hall_meta;
    logic                        hall_sync;
    logic                        hall_prev;
    logic                        hall_rise;
    logic [`POV_PERIOD_BITS-1:0] period_cnt;

    assign hall_rise = hall_sync & ~hall_prev;

    // Two sync stages, then the edge register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hall_meta  <= 1'b0;
            hall_sync  <= 1'b0;
            hall_prev  <= 1'b0;
            turn_start <= 1'b0;
        end else begin
            hall_meta  <= hall;
            hall_sync  <= hall_meta;
            hall_prev  <= hall_sync;
            turn_start <= hall_rise;
        end
    end

    // Starts at one so the captured value is the spacing of turn_start pulses
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt  <= PERIOD_ONE;
            turn_period <= '0;
        end else if (hall_rise) begin
            turn_period <= period_cnt;
            period_cnt  <= PERIOD_ONE;
        end else if (period_cnt != PERIOD_MAX) begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

endmodule

// File: source/host_cmd_port.sv
// Host must never send without credit since the queue has no overflow check
`include "pov_consts.svh"

module host_cmd_port (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               host_valid,
    input  pov_pkg::host_cmd_t host_cmd,
    output logic               host_credit,
    output pov_pkg::col_wr_t   col_wr,
    input  logic               col_grant,
    output pov_pkg::reg_wr_t   reg_wr
);

    import pov_pkg::*;

    localparam int DEPTH    = `POV_CREDITS;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(DEPTH - 1);

    host_cmd_t           queue [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    host_cmd_t           head;
    logic                head_valid;
    logic                pop;

    assign head       = queue[rd_ptr];
    assign head_valid = (count != '0);

    // Pixels wait for the buffer, register and nop entries retire at once
    assign pop = head_valid && ((head.op != op_pixel) || col_grant);

    always_comb begin
        col_wr.req   = head_valid && (head.op == op_pixel);
        col_wr.addr  = head.addr;
        col_wr.data  = head.data;
        reg_wr.valid = head_valid && (head.op != op_pixel);
        reg_wr.op    = head.op;
        reg_wr.data  = head.data;
    end

    always_ff @(posedge clk) begin
        if (host_valid) begin
            queue[wr_ptr] <= host_cmd;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            host_credit <= 1'b0;
        end else begin
            // One credit back per retired entry
            host_credit <= pop;
            if (host_valid) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({host_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/led_shifter.sv
// Driver pins trail the FSM by one cycle and a busy or disabled shifter drops slice_start
`include "pov_consts.svh"

module led_shifter (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 slice_start,
    input  logic                 display_enable,
    output logic                 rd_req,
    input  logic [`POV_LEDS-1:0] rd_data,
    output logic                 drv_sclk,
    output logic                 drv_sin,
    output logic                 drv_lat
);

    import pov_pkg::*;

    localparam int BIT_CNT_BITS = $clog2(2 * `POV_LEDS);
    localparam logic [BIT_CNT_BITS-1:0] BIT_LAST = BIT_CNT_BITS'(2 * `POV_LEDS - 1);

    shift_state_e            state;
    logic [BIT_CNT_BITS-1:0] bit_cnt;
    logic [`POV_LEDS-1:0]    shreg;

    assign rd_req = (state == s_load);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= s_idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (slice_start && display_enable) begin
                        state <= s_load;
                    end
                end
                s_load: begin
                    state   <= s_shift;
                    bit_cnt <= '0;
                end
                s_shift: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_LAST) begin
                        state <= s_latch;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Bit 0 of the counter is the clock phase, data moves on the low half
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drv_sclk <= 1'b0;
            drv_sin  <= 1'b0;
            drv_lat  <= 1'b0;
        end else begin
            drv_sclk <= (state == s_shift) && bit_cnt[0];
            drv_lat  <= (state == s_latch);
            if (state != s_shift) begin
                drv_sin <= 1'b0;
            end else if (bit_cnt == '0) begin
                drv_sin <= rd_data[`POV_LEDS-1];
            end else if (!bit_cnt[0]) begin
                drv_sin <= shreg[`POV_LEDS-1];
            end
        end
    end

    // MSB goes straight from the buffer, the rest from here
    always_ff @(posedge clk) begin
        if (state == s_shift) begin
            if (bit_cnt == '0) begin
                shreg <= rd_data << 1;
            end else if (!bit_cnt[0]) begin
                shreg <= shreg << 1;
            end
        end
    end

endmodule

// File: source/pov_consts.svh
// Slice count must be a power of two that matches POV_SLICE_BITS
`ifndef POV_CONSTS_SVH
`define POV_CONSTS_SVH

// Angular slices per turn and the width of a slice number
`define POV_SLICES 64
`define POV_SLICE_BITS 6

// LEDs in one driver chain, one bit per pixel
`define POV_LEDS 16

// Command queue depth, equal to the host's starting credits
`define POV_CREDITS 4

// Turn period counter width, the counter saturates
`define POV_PERIOD_BITS 24

`endif

// File: source/pov_pkg.sv
// Field widths come from pov_consts.svh and the opcodes fit in two bits
`include "pov_consts.svh"

package pov_pkg;

    // Host command opcodes
    typedef enum logic [1:0] {
        op_nop    = 2'd0,
        op_pixel  = 2'd1,
        op_enable = 2'd2,
        op_offset = 2'd3
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e                    op;
        logic [`POV_SLICE_BITS-1:0] addr;
        logic [`POV_LEDS-1:0]       data;
    } host_cmd_t;

    // Register write, valid for a single cycle
    typedef struct packed {
        logic                 valid;
        cmd_op_e              op;
        logic [`POV_LEDS-1:0] data;
    } reg_wr_t;

    // Framebuffer write request, held until granted
    typedef struct packed {
        logic                       req;
        logic [`POV_SLICE_BITS-1:0] addr;
        logic [`POV_LEDS-1:0]       data;
    } col_wr_t;

    typedef enum logic [1:0] {
        s_idle,
        s_load,
        s_shift,
        s_latch
    } shift_state_e;

endpackage

// File: source/pov_top.sv
// One hall input and one driver chain, and the host keeps to POV_CREDITS outstanding commands
`include "pov_consts.svh"

module pov_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        hall,
    input  logic                        host_valid,
    input  pov_pkg::host_cmd_t          host_cmd,
    output logic                        host_credit,
    output logic                        drv_sclk,
    output logic                        drv_sin,
    output logic                        drv_lat,
    output logic [`POV_PERIOD_BITS-1:0] turn_period,
    output logic [`POV_SLICE_BITS-1:0]  slice_cnt
);

    import pov_pkg::*;

    logic                       turn_start;
    logic                       slice_start;
    col_wr_t                    col_wr;
    logic                       col_grant;
    reg_wr_t                    reg_wr;
    logic                       display_enable;
    logic [`POV_SLICE_BITS-1:0] slice_offset;
    logic                       rd_req;
    logic [`POV_LEDS-1:0]       rd_data;

    // Rotation timing
    hall_counter hall_counter (
        .clk(clk), .arst_n(arst_n),
        .hall(hall),
        .turn_start(turn_start),
        .turn_period(turn_period)
    );

    slice_tracker slice_tracker (
        .clk(clk), .arst_n(arst_n),
        .turn_start(turn_start),
        .turn_period(turn_period),
        .slice_start(slice_start),
        .slice_cnt(slice_cnt)
    );

    // Host side
    host_cmd_port host_cmd_port (
        .clk(clk), .arst_n(arst_n),
        .host_valid(host_valid), .host_cmd(host_cmd), .host_credit(host_credit),
        .col_wr(col_wr), .col_grant(col_grant),
        .reg_wr(reg_wr)
    );

    display_regs display_regs (
        .clk(clk), .arst_n(arst_n),
        .reg_wr(reg_wr),
        .display_enable(display_enable),
        .slice_offset(slice_offset)
    );

    // Framebuffer and driver chain
    column_buffer column_buffer (
        .clk(clk),
        .col_wr(col_wr), .col_grant(col_grant),
        .rd_req(rd_req), .slice_cnt(slice_cnt), .slice_offset(slice_offset),
        .rd_data(rd_data)
    );

    led_shifter led_shifter (
        .clk(clk), .arst_n(arst_n),
        .slice_start(slice_start), .display_enable(display_enable),
        .rd_req(rd_req), .rd_data(rd_data),
        .drv_sclk(drv_sclk), .drv_sin(drv_sin), .drv_lat(drv_lat)
    );

endmodule

// File: source/slice_tracker.sv
// Step is the period divided by POV_SLICES and a new turn restarts the slice count at once
`include "pov_consts.svh"

module slice_tracker (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        turn_start,
    input  logic [`POV_PERIOD_BITS-1:0] turn_period,
    output logic                        slice_start,
    output logic [`POV_SLICE_BITS-1:0]  slice_cnt
);

    localparam int STEP_BITS = `POV_PERIOD_BITS - `POV_SLICE_BITS;
    localparam logic [`POV_SLICE_BITS-1:0] LAST_SLICE = `POV_SLICE_BITS'(`POV_SLICES - 1);

    logic [STEP_BITS-1:0] step;
    logic [STEP_BITS-1:0] step_cnt;
    logic                 running;

    // Never below one cycle, even for a very short first turn
    assign step = (turn_period[`POV_PERIOD_BITS-1:`POV_SLICE_BITS] == '0) ?
                  STEP_BITS'(1) : turn_period[`POV_PERIOD_BITS-1:`POV_SLICE_BITS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slice_start <= 1'b0;
            slice_cnt   <= '0;
            step_cnt    <= '0;
            running     <= 1'b0;
        end else begin
            slice_start <= 1'b0;
            if (turn_start) begin
                slice_start <= 1'b1;
                slice_cnt   <= '0;
                step_cnt    <= step - 1'b1;
                running     <= 1'b1;
            end else if (running) begin
                if (step_cnt != '0) begin
                    step_cnt <= step_cnt - 1'b1;
                end else if (slice_cnt == LAST_SLICE) begin
                    // Hold at the last slice until the hall fires again
                    running <= 1'b0;
                end else begin
                    slice_start <= 1'b1;
                    slice_cnt   <= slice_cnt + 1'b1;
                    step_cnt    <= step - 1'b1;
                end
            end
        end
    end

endmodule

// File: tests/pov_tb.sv
// Hall period is fixed at 48 cycles per slice and all pixels are written before the display runs
`include "pov_consts.svh"

module pov_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import pov_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int STEP_CYCLES  = 48;
    localparam int HALL_PERIOD  = `POV_SLICES * STEP_CYCLES;
    localparam int SEQ_CYCLES   = 2 * `POV_LEDS + 2;
    localparam int RESUME_LIMIT = STEP_CYCLES + SEQ_CYCLES + 8;
    localparam int RUN_TURNS    = 8;
    localparam int WATCHDOG_NS  = (RUN_TURNS + 2) * HALL_PERIOD * CLK_PERIOD;

    logic                        clk;
    logic                        arst_n;
    logic                        hall;
    logic                        host_valid;
    host_cmd_t                   host_cmd;
    logic                        host_credit;
    logic                        drv_sclk;
    logic                        drv_sin;
    logic                        drv_lat;
    logic [`POV_PERIOD_BITS-1:0] turn_period;
    logic [`POV_SLICE_BITS-1:0]  slice_cnt;

    logic [31:0]                lfsr;
    logic [`POV_LEDS-1:0]       model [`POV_SLICES];
    logic [`POV_SLICE_BITS-1:0] offset_val;
    logic [`POV_LEDS-1:0]       expected_col;
    logic [`POV_LEDS-1:0]       shifted;
    logic [`POV_SLICE_BITS-1:0] slice_prev;
    logic                       sclk_q;
    int                         nbits;
    int                         credits;
    int                         sent;
    int                         returned;
    int                         lat_total;
    int                         turns_seen;
    int                         value_errors;
    int                         other_errors;
    logic                       pre_cmd;
    logic                       quiet;
    logic                       cols_ready;

    pov_top uut (
        .clk(clk), .arst_n(arst_n), .hall(hall),
        .host_valid(host_valid), .host_cmd(host_cmd), .host_credit(host_credit),
        .drv_sclk(drv_sclk), .drv_sin(drv_sin), .drv_lat(drv_lat),
        .turn_period(turn_period), .slice_cnt(slice_cnt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Column the display should show, slice plus offset wrapped around the turn
    assign expected_col = model[(int'(slice_cnt) + int'(offset_val)) % `POV_SLICES];

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic send_cmd(input cmd_op_e op, input logic [`POV_SLICE_BITS-1:0] addr,
                            input logic [`POV_LEDS-1:0] data);
        while (credits == 0) begin
            @(negedge clk);
        end
        pre_cmd       = 1'b0;
        host_valid    = 1'b1;
        host_cmd.op   = op;
        host_cmd.addr = addr;
        host_cmd.data = data;
        sent++;
        @(negedge clk);
        host_valid = 1'b0;
    endtask

    // Counts latches over the next complete turn
    task automatic check_full_turn();
        int k;
        int start;
        k = turns_seen;
        wait (turns_seen == k + 1);
        start = lat_total;
        wait (turns_seen == k + 2);
        assert (lat_total - start == `POV_SLICES) else begin
            value_errors++;
            $display("FAIL drv_lat pulses per turn: got %h expected %h",
                     lat_total - start, `POV_SLICES);
        end
    endtask

    // Host side credit bookkeeping and driver pin capture
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits    <= `POV_CREDITS;
            returned   <= 0;
            lat_total  <= 0;
            slice_prev <= '0;
            sclk_q     <= 1'b0;
            nbits      <= 0;
            shifted    <= '0;
        end else begin
            credits    <= credits - int'(host_valid) + int'(host_credit);
            returned   <= returned + int'(host_credit);
            lat_total  <= lat_total + int'(drv_lat);
            slice_prev <= slice_cnt;
            sclk_q     <= drv_sclk;
            if (drv_lat) begin
                nbits <= 0;
            end else if (drv_sclk && !sclk_q) begin
                shifted <= {shifted[`POV_LEDS-2:0], drv_sin};
                nbits   <= nbits + 1;
            end
        end
    end

    credit_range: assert property (@(posedge clk) disable iff (!arst_n)
        (credits >= 0 && credits <= `POV_CREDITS))
        else begin
            other_errors++;
            $display("Host credit count left its range, now %0d", $sampled(credits));
        end

    // A credit returned early would let a command land in a full queue
    credit_spend: assert property (@(posedge clk) disable iff (!arst_n)
        host_valid |-> (credits > 0 && uut.host_cmd_port.count < `POV_CREDITS))
        else begin
            other_errors++;
            $display("Command was sent with no credit left or into a full queue");
        end

    slice_order: assert property (@(posedge clk) disable iff (!arst_n)
        (slice_cnt != slice_prev) |-> (slice_cnt == `POV_SLICE_BITS'(slice_prev + 1'b1)))
        else begin
            value_errors++;
            $display("FAIL slice_cnt: got %h expected %h", $sampled(slice_cnt),
                     `POV_SLICE_BITS'($sampled(slice_prev) + 1'b1));
        end

    col_bits: assert property (@(posedge clk) disable iff (!arst_n)
        (drv_lat && cols_ready) |-> (nbits == `POV_LEDS))
        else begin
            value_errors++;
            $display("FAIL drv_sclk rises before drv_lat: got %h expected %h",
                     $sampled(nbits), `POV_LEDS);
        end

    col_data: assert property (@(posedge clk) disable iff (!arst_n)
        (drv_lat && cols_ready) |-> (shifted == expected_col))
        else begin
            value_errors++;
            $display("FAIL drv_sin column at slice %h: got %h expected %h",
                     $sampled(slice_cnt), $sampled(shifted), $sampled(expected_col));
        end

    idle_pins: assert property (@(posedge clk)
        pre_cmd |-> (!host_credit && !drv_sclk && !drv_lat && !drv_sin))
        else begin
            other_errors++;
            $display("Credit or driver pin active before the first command");
        end

    disabled_pins: assert property (@(posedge clk) disable iff (!arst_n)
        quiet |-> (!drv_lat && !drv_sclk))
        else begin
            other_errors++;
            $display("Driver clock or latch active while the display is disabled");
        end

    // Hall square wave, turn_start follows a rise by three cycles
    initial begin : hall_gen
        wait (arst_n);
        forever begin
            repeat (HALL_PERIOD / 2) @(negedge clk);
            hall = 1'b1;
            repeat (3) @(negedge clk);
            turns_seen++;
            if (turns_seen >= 2) begin
                assert (turn_period == HALL_PERIOD) else begin
                    value_errors++;
                    $display("FAIL turn_period: got %h expected %h", turn_period, HALL_PERIOD);
                end
            end
            repeat (HALL_PERIOD / 2 - 3) @(negedge clk);
            hall = 1'b0;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns with %0d value errors and %0d other errors",
                 WATCHDOG_NS, value_errors, other_errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        logic [`POV_LEDS-1:0] word;
        int                   waited;
        clk          = 1'b0;
        arst_n       = 1'b0;
        hall         = 1'b0;
        host_valid   = 1'b0;
        host_cmd     = '0;
        lfsr         = 32'hffe0_9a96;
        offset_val   = '0;
        sent         = 0;
        turns_seen   = 0;
        value_errors = 0;
        other_errors = 0;
        pre_cmd      = 1'b1;
        quiet        = 1'b0;
        cols_ready   = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        repeat (20) @(negedge clk);

        // Fill the framebuffer, with nop bursts in between
        for (int s = 0; s < `POV_SLICES; s++) begin
            word     = `POV_LEDS'(random_bits(`POV_LEDS));
            model[s] = word;
            send_cmd(op_pixel, `POV_SLICE_BITS'(s), word);
            if (s % 16 == 7) begin
                repeat (`POV_CREDITS + 1) send_cmd(op_nop, '0, '0);
            end
            repeat (random_bits(2)) @(negedge clk);
        end
        wait (credits == `POV_CREDITS);
        cols_ready = 1'b1;

        // First turn was timed from reset, so start showing from the second
        wait (turns_seen >= 2);
        word       = `POV_LEDS'(random_bits(`POV_LEDS));
        offset_val = word[`POV_SLICE_BITS-1:0];
        send_cmd(op_offset, '0, word);
        send_cmd(op_enable, '0, 16'h0001);
        wait (credits == `POV_CREDITS);
        check_full_turn();

        // Disable, let the running column end, then expect silence for a turn
        send_cmd(op_enable, '0, `POV_LEDS'(random_bits(`POV_LEDS)) & 16'hfffe);
        wait (credits == `POV_CREDITS);
        repeat (SEQ_CYCLES + 2) @(negedge clk);
        quiet = 1'b1;
        repeat (HALL_PERIOD) @(negedge clk);
        quiet = 1'b0;

        send_cmd(op_enable, '0, 16'h0001);
        waited = 0;
        while (!drv_lat && waited < RESUME_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (drv_lat) else begin
            other_errors++;
            $display("No column latch within %0d cycles of enabling again", RESUME_LIMIT);
        end
        check_full_turn();

        wait (credits == `POV_CREDITS);
        assert (returned == sent) else begin
            value_errors++;
            $display("FAIL host_credit pulses: got %h expected %h", returned, sent);
        end

        $display("Checks done with %0d value errors and %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/pov_pkg.sv
source/hall_counter.sv
source/slice_tracker.sv
source/host_cmd_port.sv
source/display_regs.sv
source/column_buffer.sv
source/led_shifter.sv
source/pov_top.sv
tests/pov_tb.sv
